//--- rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // base integer ISA widths
  localparam int xlen      = 32;
  localparam int opcode_w  = 7;
  localparam int funct3_w  = 3;
  localparam int funct7_w  = 7;
  localparam int reg_idx_w = 5;
  localparam int imm_i_w   = 12;
  localparam int imm_u_w   = 20;

  typedef logic [xlen-1:0]      word_t;
  typedef logic [reg_idx_w-1:0] reg_idx_t;
  typedef logic [opcode_w-1:0]  opcode_t;
  typedef logic [funct3_w-1:0]  funct3_t;
  typedef logic [funct7_w-1:0]  funct7_t;

  // major opcodes kept by this core
  localparam opcode_t op_lui     = 7'b01_101_11;
  localparam opcode_t op_auipc   = 7'b00_101_11;
  localparam opcode_t op_reg_imm = 7'b00_100_11;
  localparam opcode_t op_reg_reg = 7'b01_100_11;
  localparam opcode_t op_environ = 7'b11_100_11;

  // funct3 for the integer alu group, shared by imm and reg forms
  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101;
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // alt selects sub and sra
  localparam funct7_t f7_base = 7'b000_0000;
  localparam funct7_t f7_alt  = 7'b010_0000;

  typedef struct packed {
    funct7_t  funct7;
    reg_idx_t rs2;
    reg_idx_t rs1;
    funct3_t  funct3;
    reg_idx_t rd;
    opcode_t  opcode;
  } r_type_t;

  typedef struct packed {
    logic [imm_i_w-1:0] imm;
    reg_idx_t           rs1;
    funct3_t            funct3;
    reg_idx_t           rd;
    opcode_t            opcode;
  } i_type_t;

  typedef struct packed {
    logic [imm_u_w-1:0] imm;
    reg_idx_t           rd;
    opcode_t            opcode;
  } u_type_t;

  // one instruction word, three decodings
  typedef union packed {
    r_type_t r;
    i_type_t i;
    u_type_t u;
  } rv_insn_t;

endpackage

`default_nettype wire

//--- rtl/core_pkg.sv
`default_nettype none

package core_pkg;
  import rv_isa_pkg::*;

  // instruction queue size, also the initial credit count
  localparam int queue_depth = 4;

  typedef logic [$clog2(queue_depth)-1:0] qptr_t;
  // counts run 0..queue_depth inclusive
  typedef logic [$clog2(queue_depth):0]   credit_t;
  typedef logic [$clog2(queue_depth):0]   count_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
  } fetch_req_t;

  typedef struct packed {
    word_t    pc;
    rv_insn_t insn;
  } queue_entry_t;

  typedef struct packed {
    logic     valid;
    logic     illegal;
    reg_idx_t rd;
    word_t    data;
  } retire_t;

endpackage

`default_nettype wire

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
  import rv_isa_pkg::*, core_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         credit_return,
  input  word_t        imem_insn,
  output fetch_req_t   imem_req,
  output logic         push_valid,
  output queue_entry_t push_entry
);

  credit_t credits;
  word_t   next_pc;
  word_t   pend_pc;
  logic    issue;

  // a credit guarantees a free queue slot for the response
  assign issue = credits != '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      credits    <= credit_t'(queue_depth);
      next_pc    <= '0;
      imem_req   <= '0;
      push_valid <= 1'b0;
    end else begin
      credits        <= credits - credit_t'(issue) + credit_t'(credit_return);
      imem_req.valid <= issue;
      imem_req.pc    <= next_pc;
      if (issue) begin
        next_pc <= next_pc + word_t'(4);
      end
      // memory answers exactly one cycle after the request
      push_valid <= imem_req.valid;
    end
  end

  // pc of the request now in flight
  always_ff @(posedge clk) begin
    pend_pc <= imem_req.pc;
  end

  assign push_entry = '{pc: pend_pc, insn: rv_insn_t'(imem_insn)};

endmodule

`default_nettype wire

//--- rtl/insn_queue.sv
`timescale 1ns/1ps
`default_nettype none

module insn_queue
  import core_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         push_valid,
  input  queue_entry_t push_entry,
  input  logic         pop,
  output queue_entry_t head,
  output logic         not_empty,
  output logic         credit_return
);

  queue_entry_t slots [queue_depth];
  qptr_t        wr_ptr;
  qptr_t        rd_ptr;
  count_t       count;

  // entry storage
  always_ff @(posedge clk) begin
    if (push_valid) begin
      slots[wr_ptr] <= push_entry;
    end
  end

  // pointers wrap at the power-of-two depth
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_valid) begin
        wr_ptr <= wr_ptr + qptr_t'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + qptr_t'(1);
      end
      // credits keep every push away from a full queue
      count <= count + count_t'(push_valid) - count_t'(pop);
    end
  end

  assign head      = slots[rd_ptr];
  assign not_empty = count != '0;

  // each freed slot goes straight back to fetch
  assign credit_return = pop;

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import rv_isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     we,
  input  reg_idx_t rd,
  input  word_t    rd_data
);

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int idx = 1; idx < 32; idx++) begin
        regs[idx] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- rtl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit
  import rv_isa_pkg::*, core_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  queue_entry_t head,
  input  logic         not_empty,
  output logic         pop,
  output retire_t      retire,
  output logic         halt
);

  rv_insn_t               insn;
  word_t                  rs1_data;
  word_t                  rs2_data;
  word_t                  imm_i;
  word_t                  imm_u;
  word_t                  op_b;
  logic [$clog2(xlen)-1:0] shamt;
  logic                   is_reg;
  logic                   use_alt;
  logic                   alt_ok;
  logic                   need_f7;
  logic                   f7_ok;
  logic                   legal;
  logic                   writes;
  logic                   ecall_ok;
  logic                   rf_we;
  word_t                  alu_out;
  word_t                  result;

  assign insn = head.insn;
  assign pop  = not_empty && !halt;

  assign imm_i = {{(xlen - imm_i_w){insn.i.imm[imm_i_w-1]}}, insn.i.imm};
  assign imm_u = {insn.u.imm, 12'b0};

  // operand b and shift amount depend on imm vs reg form
  assign is_reg = insn.r.opcode == op_reg_reg;
  assign op_b   = is_reg ? rs2_data : imm_i;
  assign shamt  = is_reg ? rs2_data[$clog2(xlen)-1:0] : insn.r.rs2;

  // shifts and reg forms need funct7 base unless alt selects sub or sra
  assign use_alt = insn.r.funct7 == f7_alt;
  assign alt_ok  = (insn.r.funct3 == f3_sr) || (is_reg && insn.r.funct3 == f3_add);
  assign need_f7 = is_reg || insn.r.funct3 == f3_sll || insn.r.funct3 == f3_sr;
  assign f7_ok   = !need_f7 || insn.r.funct7 == f7_base || (use_alt && alt_ok);

  reg_file i_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (insn.r.rs1),
    .rs2      (insn.r.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .rd       (insn.r.rd),
    .rd_data  (result)
  );

  always_comb begin
    case (insn.r.funct3)
      f3_add:  alu_out = (is_reg && use_alt) ? rs1_data - op_b : rs1_data + op_b;
      f3_sll:  alu_out = rs1_data << shamt;
      f3_slt:  alu_out = word_t'($signed(rs1_data) < $signed(op_b));
      f3_sltu: alu_out = word_t'(rs1_data < op_b);
      f3_xor:  alu_out = rs1_data ^ op_b;
      f3_sr:   alu_out = use_alt ? word_t'($signed(rs1_data) >>> shamt) : rs1_data >> shamt;
      f3_or:   alu_out = rs1_data | op_b;
      f3_and:  alu_out = rs1_data & op_b;
    endcase
  end

  always_comb begin
    legal    = 1'b1;
    writes   = 1'b1;
    ecall_ok = 1'b0;
    result   = alu_out;
    case (insn.r.opcode)
      op_lui:     result = imm_u;
      op_auipc:   result = head.pc + imm_u;
      op_reg_imm: legal = f7_ok;
      op_reg_reg: legal = f7_ok;
      op_environ: begin
        // only the all-zero form is ecall
        writes   = 1'b0;
        legal    = (insn.u.imm == '0) && (insn.u.rd == '0);
        ecall_ok = legal;
      end
      default:    legal = 1'b0;
    endcase
    if (!legal) begin
      writes = 1'b0;
      result = '0;
    end
  end

  assign rf_we = pop && writes;

  always_ff @(posedge clk) begin
    if (rst) begin
      retire <= '0;
      halt   <= 1'b0;
    end else begin
      // ecall halts without a retire record
      retire.valid   <= pop && !ecall_ok;
      retire.illegal <= !legal;
      retire.rd      <= insn.r.rd;
      retire.data    <= result;
      if (pop && ecall_ok) begin
        halt <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top
  import rv_isa_pkg::*, core_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  output fetch_req_t imem_req,
  input  word_t      imem_insn,
  output retire_t    retire,
  output logic       halt
);

  logic         push_valid;
  queue_entry_t push_entry;
  logic         credit_return;
  queue_entry_t head;
  logic         not_empty;
  logic         pop;

  fetch_unit i_fetch_unit (
    .clk           (clk),
    .rst           (rst),
    .credit_return (credit_return),
    .imem_insn     (imem_insn),
    .imem_req      (imem_req),
    .push_valid    (push_valid),
    .push_entry    (push_entry)
  );

  insn_queue i_insn_queue (
    .clk           (clk),
    .rst           (rst),
    .push_valid    (push_valid),
    .push_entry    (push_entry),
    .pop           (pop),
    .head          (head),
    .not_empty     (not_empty),
    .credit_return (credit_return)
  );

  exec_unit i_exec_unit (
    .clk       (clk),
    .rst       (rst),
    .head      (head),
    .not_empty (not_empty),
    .pop       (pop),
    .retire    (retire),
    .halt      (halt)
  );

endmodule

`default_nettype wire

//--- dv/core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module core_queue_assert
  import core_pkg::*;
(
  input logic   clk,
  input logic   rst,
  input logic   push_valid,
  input logic   pop,
  input logic   not_empty,
  input count_t count
);

  // assertion failures so far
  int fail_count = 0;

  // occupancy bounded by the queue size
  occupancy_bound: assert property (@(posedge clk) disable iff (rst)
    count <= count_t'(queue_depth))
    else begin
      $error("queue occupancy above depth");
      fail_count++;
    end

  // credits keep a full queue from being pushed
  no_push_full: assert property (@(posedge clk) disable iff (rst)
    !(push_valid && count == count_t'(queue_depth)))
    else begin
      $error("push into a full queue");
      fail_count++;
    end

  pop_needs_entry: assert property (@(posedge clk) disable iff (rst)
    pop |-> not_empty)
    else begin
      $error("pop while queue empty");
      fail_count++;
    end

endmodule

bind insn_queue core_queue_assert i_queue_assert (
  .clk        (clk),
  .rst        (rst),
  .push_valid (push_valid),
  .pop        (pop),
  .not_empty  (not_empty),
  .count      (count)
);

`default_nettype wire

//--- dv/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb
  import rv_isa_pkg::*, core_pkg::*;
();

  localparam int    clk_half       = 4;
  localparam int    reset_cycles   = 4;
  localparam int    timeout_cycles = 50;
  localparam int    stim_depth     = 64;
  localparam word_t ecall_word     = {25'b0, op_environ};

  logic       clk;
  logic       rst;
  fetch_req_t imem_req;
  word_t      imem_insn;
  retire_t    retire;
  logic       halt;

  // program word then {pad, valid, illegal, rd, data} on each line
  logic [71:0] stim [stim_depth];
  int          prog_len     = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;
  int          check_errors = 0;
  int          req_errors   = 0;
  int          req_count    = 0;
  int          retire_count = 0;
  word_t       next_req_pc;

  core_top i_dut (
    .clk       (clk),
    .rst       (rst),
    .imem_req  (imem_req),
    .imem_insn (imem_insn),
    .retire    (retire),
    .halt      (halt)
  );

  initial begin
    clk = 1'b0;
    forever #clk_half clk = ~clk;
  end

  // program ends in ecall words past the last line
  function automatic word_t fetch_word(input word_t pc);
    int idx;
    idx = int'(pc >> 2);
    if (idx < prog_len) begin
      return stim[idx][71:40];
    end
    return ecall_word;
  endfunction

  task automatic check_retire(input string name, input retire_t want, input retire_t got,
                              inout int fails);
    if (got !== want) begin
      $display("FAILED %s expected 0x%h actual 0x%h", name, want, got);
      fails++;
    end
  endtask

  task automatic check_halt(input string name, input logic want, input logic got,
                            inout int fails);
    if (got !== want) begin
      $display("FAILED %s expected 0x%h actual 0x%h", name, want, got);
      fails++;
    end
  endtask

  task automatic check_req(input string name, input fetch_req_t want, input fetch_req_t got,
                           inout int fails);
    if (got !== want) begin
      $display("FAILED %s expected 0x%h actual 0x%h", name, want, got);
      fails++;
    end
  endtask

  task automatic end_test(input string name, input int fails);
    tests_run++;
    if (fails == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      check_errors += fails;
      $display("test %s: failed", name);
    end
  endtask

  task automatic load_stimulus();
    $readmemh("dv/core_stimulus.hex", stim);
    prog_len = 0;
    while (prog_len < stim_depth && !$isunknown(stim[prog_len])) begin
      prog_len++;
    end
  endtask

  task automatic wait_retire(output bit seen);
    int waited;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
      seen = retire.valid;
    end
  endtask

  task automatic wait_halt(output bit seen);
    int waited;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
      seen = halt;
    end
  endtask

  // instruction memory with one cycle of latency and no stalls
  always @(posedge clk) begin
    if (imem_req.valid) begin
      imem_insn <= fetch_word(imem_req.pc);
    end
  end

  // requests walk the program in steps of one word
  always @(posedge clk) begin : req_monitor
    fetch_req_t want;
    if (rst) begin
      next_req_pc <= '0;
    end else if (imem_req.valid) begin
      want.valid = 1'b1;
      want.pc    = next_req_pc;
      check_req("imem_req", want, imem_req, req_errors);
      next_req_pc <= next_req_pc + word_t'(4);
      req_count   <= req_count + 1;
    end
  end

  always @(posedge clk) begin
    if (!rst && retire.valid) begin
      retire_count <= retire_count + 1;
    end
  end

  initial begin
    int         fails;
    int         idx;
    bit         seen;
    bit         stop;
    retire_t    got;
    fetch_req_t idle_req;

    rst       = 1'b1;
    imem_insn = '0;
    idle_req  = '0;
    stop      = 1'b0;
    load_stimulus();
    if (prog_len == 0) begin
      $display("stimulus file holds no program lines");
      end_test("stimulus load", 1);
      stop = 1'b1;
    end

    // reset and the first cycle out of it
    fails = 0;
    for (int cyc = 0; cyc < reset_cycles; cyc++) begin
      @(posedge clk);
      if (cyc == reset_cycles - 1) begin
        rst <= 1'b0;
      end
      @(negedge clk);
      got       = '0;
      got.valid = retire.valid;
      check_retire("retire.valid", '0, got, fails);
      check_halt("halt", 1'b0, halt, fails);
      check_req("imem_req", idle_req, imem_req, fails);
    end
    @(negedge clk);
    got       = '0;
    got.valid = retire.valid;
    check_retire("retire.valid", '0, got, fails);
    check_halt("halt", 1'b0, halt, fails);
    end_test("reset", fails);

    // one retire per line in program order
    idx = 0;
    while (!stop && idx < prog_len && stim[idx][38:0] != '0) begin
      fails = 0;
      wait_retire(seen);
      if (seen) begin
        check_retire("retire", retire_t'(stim[idx][38:0]), retire, fails);
      end else begin
        $display("timeout: no retire for line %0d within %0d cycles", idx, timeout_cycles);
        fails++;
        stop = 1'b1;
      end
      end_test($sformatf("line %0d", idx), fails);
      idx++;
    end

    if (!stop && idx < prog_len) begin
      fails = 0;
      wait_halt(seen);
      if (!seen) begin
        $display("timeout: halt did not rise after the ecall on line %0d", idx);
        fails++;
      end else begin
        // halt holds and nothing else retires
        repeat (timeout_cycles) begin
          @(negedge clk);
          check_halt("halt", 1'b1, halt, fails);
        end
        if (retire_count != idx) begin
          $display("FAILED retire_count expected 0x%h actual 0x%h", idx, retire_count);
          fails++;
        end
      end
      end_test("halt", fails);
    end else if (!stop) begin
      $display("stimulus holds no ecall line, so halt was never reached");
      end_test("halt", 1);
    end

    if (req_count == 0) begin
      $display("no instruction memory request was seen");
      req_errors++;
    end
    end_test("request pc", req_errors);

    end_test("queue protocol", i_dut.i_insn_queue.i_queue_assert.fail_count);

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, check_errors);
    if (tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- core_top.f
rtl/rv_isa_pkg.sv
rtl/core_pkg.sv
rtl/fetch_unit.sv
rtl/insn_queue.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/core_top.sv
dv/core_assert.sv
dv/core_tb.sv

//--- dv/core_stimulus.hex
// columns: program word _ {0, valid, illegal, rd[4:0]} _ expected retire data
// an all-zero retire part marks the ecall, where halt is expected instead
00500093_41_00000005 // addi x1, x0, 5
FFD00113_42_FFFFFFFD // addi x2, x0, -3
FFF12193_43_00000001 // slti x3, x2, -1
FFF0B213_44_00000001 // sltiu x4, x1, -1
0F00C293_45_000000F5 // xori x5, x1, 0x0f0
7002E313_46_000007F5 // ori x6, x5, 0x700
0FF37393_47_000000F5 // andi x7, x6, 0x0ff
00409413_48_00000050 // slli x8, x1, 4
01C15493_49_0000000F // srli x9, x2, 28
40115513_4A_FFFFFFFE // srai x10, x2, 1
401505B3_4B_FFFFFFF9 // sub x11, x10, x1
4035D633_4C_FFFFFFFC // sra x12, x11, x3
001626B3_4D_00000001 // slt x13, x12, x1
00C6B733_4E_00000001 // sltu x14, x13, x12
00B707B3_4F_FFFFFFFA // add x15, x14, x11
12345037_40_12345000 // lui x0, 0x12345
00001817_50_00001040 // auipc x16, 0x1 at pc 0x40
0000087F_70_00000000 // unknown opcode, rd x16
02080833_70_00000000 // add x16, x16, x0 with funct7 0x01
000808B3_51_00001040 // add x17, x16, x0
00000073_00_00000000 // ecall
